// File: logic/dqla_pkg.sv
// Shared definitions for the dual-quad I/O expander link
// Address map, frame layout and widths used by ports, arbiter and shifter
`default_nettype none

package dqla_pkg;

    // ------------------------------
    // Address map
    // ------------------------------
    localparam logic [3:0] ADDR_MAIN = 4'h0;    // Space field, reg address bits 15:12
    localparam logic [3:0] OFF_IOEXP = 4'd12;   // Register offset, bits 3:0

    // ------------------------------
    // Widths
    // ------------------------------
    localparam int FRAME_W  = 16;               // Bits per SPI frame
    localparam int RSP_W    = 16;               // Bits captured from miso
    localparam int NUM_QUAD = 2;                // Q1 and Q2

    // Command view of a frame, MSB goes out first
    typedef struct packed {
        logic       rd;                         // 1 -> read back register
        logic [6:0] addr;                       // Expander register address
        logic [7:0] data;                       // Write data, ignored on read
    } ioexp_cmd_t;

    // Same 16 bits, seen as command by the ports and as a word by the shifter
    typedef union packed {
        ioexp_cmd_t         cmd;
        logic [FRAME_W-1:0] raw;
    } ioexp_frame_u;

endpackage

`default_nettype wire

// File: logic/spi_bus_if.sv
// Request/completion link for one SPI frame
// Used between each port and the arbiter, and between arbiter and shifter
`timescale 1ns/1ps
`default_nettype none

interface spi_bus_if;

    logic                       req;     // Held high until done
    dqla_pkg::ioexp_frame_u     frame;   // Stable while req is high
    logic                       grant;   // Frame owns the wires
    logic                       done;    // One-cycle completion pulse
    logic [dqla_pkg::RSP_W-1:0] rsp;     // Valid with done
    logic                       sel;     // Quad index, 0 -> Q1

    modport requester (output req, frame, sel, input grant, done, rsp);
    modport arbiter   (input req, frame, sel, output grant, done, rsp);
    modport shifter   (input req, frame, sel, output grant, done, rsp);

endinterface

`default_nettype wire

// File: logic/ioexp_port.sv
// I/O expander port for one quad
// Decodes host writes into a frame request, keeps busy, valid and last response
`timescale 1ns/1ps
`default_nettype none

module ioexp_port #(
    parameter int QUAD_ID = 1                   // Channel field, 1 -> Q1, 2 -> Q2
) (
    input  wire         sysclk,
    input  wire         arst_n,
    input  wire  [15:0] reg_waddr,
    input  wire  [31:0] reg_wdata,
    input  wire         reg_wen,
    output logic [31:0] status,                 // {busy, valid, 0, rsp}
    spi_bus_if.requester bus
);

    logic                       wr_hit;         // Write addressed to this port
    logic                       accept;         // Write taken, port was idle
    logic                       req_q;          // Request pending, also busy bit
    logic                       valid_q;        // At least one frame completed
    logic [dqla_pkg::RSP_W-1:0] rsp_q;          // Last response
    dqla_pkg::ioexp_frame_u     frame_q;

    // ------------------------------
    // Write decode
    // ------------------------------
    assign wr_hit = reg_wen
                 && (reg_waddr[15:12] == dqla_pkg::ADDR_MAIN)
                 && (reg_waddr[7:4] == 4'(QUAD_ID))
                 && (reg_waddr[3:0] == dqla_pkg::OFF_IOEXP);

    assign accept = wr_hit && !req_q;           // Busy port drops the write

    // ------------------------------
    // Request and status
    // ------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            req_q   <= 1'b0;
            valid_q <= 1'b0;
            rsp_q   <= '0;
        end else if (accept) begin
            req_q <= 1'b1;                      // Seen by arbiter next cycle
        end else if (bus.done) begin
            req_q   <= 1'b0;                    // Busy reads low after done
            valid_q <= 1'b1;
            rsp_q   <= bus.rsp;
        end
    end

    // Low half of the write word split into command fields
    always_ff @(posedge sysclk) begin
        if (accept) begin
            frame_q.cmd.rd   <= reg_wdata[15];
            frame_q.cmd.addr <= reg_wdata[14:8];
            frame_q.cmd.data <= reg_wdata[7:0];
        end
    end

    assign bus.req   = req_q;
    assign bus.frame = frame_q;
    assign bus.sel   = 1'(QUAD_ID - 1);         // Quad index for chip select

    assign status = {req_q, valid_q, {(30 - dqla_pkg::RSP_W){1'b0}}, rsp_q};

    // ------------------------------
    // Checks
    // ------------------------------
    // Frame may not move under the shifter
    frame_hold_a: assert property (@(posedge sysclk) disable iff (!arst_n)
        (bus.req && !bus.done) |=> $stable(bus.frame.raw));

    // Completion only comes back to the port that owns the wires
    done_owner_a: assert property (@(posedge sysclk) disable iff (!arst_n)
        bus.done |-> (bus.grant && bus.req));

endmodule

`default_nettype wire

// File: logic/spi_bus_arbiter.sv
// Fixed-priority arbiter, Q1 ahead of Q2
// Puts one port at a time on the shared serializer
`timescale 1ns/1ps
`default_nettype none

module spi_bus_arbiter (
    input  wire         sysclk,
    input  wire         arst_n,
    spi_bus_if.arbiter  q1,
    spi_bus_if.arbiter  q2,
    spi_bus_if.requester out
);

    logic owner_q;                              // 0 -> Q1, 1 -> Q2
    logic busy_q;                               // Frame requested or in flight

    // Owner latched only while idle
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            owner_q <= 1'b0;
            busy_q  <= 1'b0;
        end else if (busy_q) begin
            if (out.done)
                busy_q <= 1'b0;                 // One idle cycle follows
        end else if (q1.req) begin
            owner_q <= 1'b0;
            busy_q  <= 1'b1;
        end else if (q2.req) begin
            owner_q <= 1'b1;
            busy_q  <= 1'b1;
        end
    end

    // ------------------------------
    // Forward path, owner only
    // ------------------------------
    assign out.req   = busy_q;
    assign out.frame = owner_q ? q2.frame : q1.frame;
    assign out.sel   = owner_q ? q2.sel : q1.sel;

    // Return path
    assign q1.grant = busy_q && !owner_q;
    assign q2.grant = busy_q && owner_q;
    assign q1.done  = out.done && q1.grant;
    assign q2.done  = out.done && q2.grant;
    assign q1.rsp   = q1.grant ? out.rsp : '0;
    assign q2.rsp   = q2.grant ? out.rsp : '0;

    grant_excl_a: assert property (@(posedge sysclk) disable iff (!arst_n)
        !(q1.grant && q2.grant));

    // Shifter ends only a frame it was running
    done_after_run_a: assert property (@(posedge sysclk) disable iff (!arst_n)
        out.done |-> $past(out.grant));

endmodule

`default_nettype wire

// File: logic/spi_shifter.sv
// Shared SPI serializer for both expanders
// Makes sclk, drives the selected chip select, shifts frame out and response in
`timescale 1ns/1ps
`default_nettype none

module spi_shifter #(
    parameter int SCLK_DIV = 2                  // sysclk cycles per sclk half period
) (
    input  wire         sysclk,
    input  wire         arst_n,
    spi_bus_if.shifter  bus,
    output logic        sclk,
    output logic        mosi,
    input  wire         miso,
    output logic [dqla_pkg::NUM_QUAD-1:0] ioexp_csn
);

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;
    localparam int BIT_W = $clog2(dqla_pkg::FRAME_W);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCLK_DIV - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(dqla_pkg::FRAME_W - 1);

    logic                       active;         // Frame on the wires
    logic                       half_end;       // Last cycle of a half period
    logic [DIV_W-1:0]           div_cnt;        // Half-period counter
    logic [BIT_W-1:0]           bit_cnt;        // Bit being sent, 0 is MSB
    logic                       sclk_q;
    logic                       done_q;
    logic [dqla_pkg::RSP_W-1:0] rx_sr;          // miso shift register

    assign active   = bus.req && !done_q;       // Drops in the done cycle
    assign half_end = active && (div_cnt == DIV_LAST);

    // ------------------------------
    // Clock and bit timing
    // ------------------------------
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            bit_cnt <= '0;
            sclk_q  <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (half_end) begin
                div_cnt <= '0;
                sclk_q  <= ~sclk_q;
                if (sclk_q) begin               // Falling edge, next bit
                    bit_cnt <= bit_cnt + 1'b1;  // Wraps to 0 after the last bit
                    if (bit_cnt == BIT_LAST)
                        done_q <= 1'b1;
                end
            end else if (active) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Sample on the rising sclk edge
    always_ff @(posedge sysclk) begin
        if (half_end && !sclk_q)
            rx_sr <= {rx_sr[dqla_pkg::RSP_W-2:0], miso};
    end

    // ------------------------------
    // Pins and completion
    // ------------------------------
    assign sclk = sclk_q;
    assign mosi = active && bus.frame.raw[BIT_LAST - bit_cnt];   // MSB first

    always_comb begin
        for (int i = 0; i < dqla_pkg::NUM_QUAD; i++) begin
            ioexp_csn[i] = !(active && (int'(bus.sel) == i));
        end
    end

    assign bus.grant = active;
    assign bus.done  = done_q;
    assign bus.rsp   = rx_sr;

    csn_onehot_a: assert property (@(posedge sysclk) disable iff (!arst_n)
        active ? $onehot(~ioexp_csn) : (&ioexp_csn));

    // Arbiter keeps the target fixed for the whole frame
    sel_hold_a: assert property (@(posedge sysclk) disable iff (!arst_n)
        (active && $past(active)) |-> $stable(bus.sel));

endmodule

`default_nettype wire

// File: logic/dqla_ioexp_top.sv
// Dual-quad I/O expander link, top level
// Two expander ports share one SPI bus through a fixed-priority arbiter
`timescale 1ns/1ps
`default_nettype none

module dqla_ioexp_top #(
    parameter int SCLK_DIV = 2                  // sysclk cycles per sclk half period
) (
    input  wire         sysclk,
    input  wire         arst_n,
    input  wire  [15:0] reg_raddr,
    input  wire  [15:0] reg_waddr,
    input  wire  [31:0] reg_wdata,
    input  wire         reg_wen,
    output logic [31:0] reg_rdata,
    output logic        sclk,
    output logic        mosi,
    input  wire         miso,
    output logic [dqla_pkg::NUM_QUAD-1:0] ioexp_csn
);

    logic [31:0] status_q1;
    logic [31:0] status_q2;
    logic        rd_ioexp;                      // Read hits an expander offset

    spi_bus_if port_q1_bus ();
    spi_bus_if port_q2_bus ();
    spi_bus_if shift_bus ();

    // ------------------------------
    // Ports, arbiter, serializer
    // ------------------------------
    ioexp_port #(.QUAD_ID(1)) port_q1_i (
        .sysclk(sysclk), .arst_n(arst_n), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen), .status(status_q1), .bus(port_q1_bus)
    );

    ioexp_port #(.QUAD_ID(2)) port_q2_i (
        .sysclk(sysclk), .arst_n(arst_n), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .reg_wen(reg_wen), .status(status_q2), .bus(port_q2_bus)
    );

    spi_bus_arbiter arb_i (
        .sysclk(sysclk), .arst_n(arst_n), .q1(port_q1_bus), .q2(port_q2_bus),
        .out(shift_bus)
    );

    spi_shifter #(.SCLK_DIV(SCLK_DIV)) shifter_i (
        .sysclk(sysclk), .arst_n(arst_n), .bus(shift_bus), .sclk(sclk), .mosi(mosi),
        .miso(miso), .ioexp_csn(ioexp_csn)
    );

    // Read mux, channel field picks the quad
    assign rd_ioexp = (reg_raddr[15:12] == dqla_pkg::ADDR_MAIN)
                   && (reg_raddr[3:0] == dqla_pkg::OFF_IOEXP);

    assign reg_rdata = !rd_ioexp                ? 32'd0 :
                       (reg_raddr[7:4] == 4'd1) ? status_q1 :
                       (reg_raddr[7:4] == 4'd2) ? status_q2 : 32'd0;

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source
// Free-running sysclk, arst_n held low for a few cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 100,             // ns
    parameter int RST_CYCLES = 3
) (
    output logic sysclk,
    output logic arst_n
);

    initial begin
        sysclk = 1'b0;
        forever #(PERIOD / 2) sysclk = ~sysclk;
    end

    // Release away from the rising edge
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge sysclk);
        @(negedge sysclk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_ioexp_model.sv
// Behavioural model of the two quad I/O expanders on one SPI bus
// Each has its own register file, frames are logged for the testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ioexp_model (
    input  wire       sclk,
    input  wire       mosi,
    input  wire [1:0] ioexp_csn,                // Bit 0 -> Q1
    output logic      miso
);

    logic [7:0]             regs [0:1][0:15];   // Register file per expander
    dqla_pkg::ioexp_frame_u log_frame [0:15];   // Frames in arrival order
    logic                   log_quad [0:15];    // 0 -> Q1, 1 -> Q2
    int                     frame_cnt;
    int                     bit_cnt;
    logic                   qsel;
    logic [15:0]            rx;
    logic [15:0]            tx;                 // Response, MSB first
    dqla_pkg::ioexp_frame_u f;

    initial begin
        miso      = 1'b0;
        frame_cnt = 0;
        bit_cnt   = 0;
        tx        = '0;
        for (int q = 0; q < 2; q++)
            for (int a = 0; a < 16; a++)
                regs[q][a] = '0;
    end

    // ------------------------------
    // Shift in on rising sclk
    // ------------------------------
    always @(posedge sclk) begin
        if (ioexp_csn != 2'b11) begin
            if (bit_cnt == 0) begin
                qsel = ioexp_csn[0];            // Q1 select low -> 0
                tx   = '0;
            end
            rx      = {rx[14:0], mosi};
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8) begin             // rd and addr known
                f.raw = {rx[7:0], 8'h00};
                if (f.cmd.rd)
                    tx = {8'h00, regs[qsel][f.cmd.addr[3:0]]};
            end
            if (bit_cnt == 16) begin
                f.raw = rx;
                if (!f.cmd.rd)
                    regs[qsel][f.cmd.addr[3:0]] = f.cmd.data;
                log_frame[frame_cnt] = f;
                log_quad[frame_cnt]  = qsel;
                frame_cnt = frame_cnt + 1;
                bit_cnt   = 0;
            end
        end
    end

    // Next response bit goes out while sclk is low
    always @(negedge sclk) begin
        miso <= (bit_cnt > 0 && bit_cnt < 16) ? tx[15 - bit_cnt] : 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/tb_dqla_ioexp.sv
// Directed testbench for the dual-quad I/O expander link
// Host register writes start frames, the expander model answers on the SPI bus
`timescale 1ns/1ps
`default_nettype none

module tb_dqla_ioexp;

    localparam int SCLK_DIV     = 2;
    localparam int CLK_PERIOD   = 100;                                  // ns
    localparam int NUM_FRAMES   = 8;                                    // Frames over all tests
    localparam int WATCHDOG_CYC = NUM_FRAMES * 32 * SCLK_DIV * 2 + 200;

    wire         sysclk;
    wire         arst_n;
    wire  [31:0] reg_rdata;
    wire         sclk;
    wire         mosi;
    wire         miso;
    wire  [1:0]  ioexp_csn;
    logic [15:0] reg_raddr;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    int          exp_frames;                    // Frames the model should have seen

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(3)) clock_gen_i (
        .sysclk(sysclk), .arst_n(arst_n)
    );

    dqla_ioexp_top #(.SCLK_DIV(SCLK_DIV)) dqla_ioexp_top_i (
        .sysclk(sysclk), .arst_n(arst_n), .reg_raddr(reg_raddr), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen), .reg_rdata(reg_rdata), .sclk(sclk),
        .mosi(mosi), .miso(miso), .ioexp_csn(ioexp_csn)
    );

    tb_ioexp_model model_i (.sclk(sclk), .mosi(mosi), .ioexp_csn(ioexp_csn), .miso(miso));

    // ------------------------------
    // Failure reporting and compares
    // ------------------------------
    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_status(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        if (got !== exp)
            value_error($sformatf("%s: status 0x%08h, expected 0x%08h", what, got, exp));
    endtask

    task automatic check_frame(input dqla_pkg::ioexp_frame_u got,
                               input dqla_pkg::ioexp_frame_u exp, input string what);
        if (got.raw !== exp.raw)
            value_error($sformatf("%s: frame rd %b addr 0x%02h data 0x%02h, expected 0x%04h",
                                  what, got.cmd.rd, got.cmd.addr, got.cmd.data, exp.raw));
    endtask

    task automatic check_pins(input logic [2:0] got, input logic [2:0] exp, input string what);
        if (got !== exp)
            value_error($sformatf("%s: {sclk, csn} %b, expected %b", what, got, exp));
    endtask

    // ------------------------------
    // Frame and address helpers
    // ------------------------------
    function automatic logic [15:0] port_addr(input logic [3:0] quad_id);
        return {dqla_pkg::ADDR_MAIN, 4'h0, quad_id, dqla_pkg::OFF_IOEXP};
    endfunction

    function automatic dqla_pkg::ioexp_frame_u make_frame(input logic rd,
                                                          input logic [6:0] addr,
                                                          input logic [7:0] data);
        dqla_pkg::ioexp_frame_u f;
        f.cmd.rd   = rd;
        f.cmd.addr = addr;
        f.cmd.data = data;
        return f;
    endfunction

    // Idle with valid set and the last response in the low half
    function automatic logic [31:0] done_status(input logic [15:0] rsp);
        return {1'b0, 1'b1, 14'd0, rsp};
    endfunction

    task automatic write_reg(input logic [15:0] addr, input dqla_pkg::ioexp_frame_u f);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= {16'h0000, f.raw};
        reg_wen   <= 1'b1;
    endtask

    task automatic end_write();
        @(posedge sysclk);
        reg_wen <= 1'b0;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(negedge sysclk);                      // Read mux settled
        data = reg_rdata;
    endtask

    // Busy bit low ends the frame, watchdog bounds the wait
    task automatic wait_idle(input logic [3:0] quad_id);
        logic [31:0] st;
        read_reg(port_addr(quad_id), st);
        while (st[31])
            read_reg(port_addr(quad_id), st);
    endtask

    task automatic send_frame(input logic [3:0] quad_id, input dqla_pkg::ioexp_frame_u f);
        write_reg(port_addr(quad_id), f);
        end_write();
        wait_idle(quad_id);
    endtask

    task automatic expect_logged(input logic qsel, input dqla_pkg::ioexp_frame_u f);
        exp_frames = exp_frames + 1;
        if (model_i.frame_cnt < exp_frames)
            value_error($sformatf("model holds %0d frames, frame %0d missing",
                                  model_i.frame_cnt, exp_frames));
        check_frame(model_i.log_frame[exp_frames - 1], f, "model frame");
        if (model_i.log_quad[exp_frames - 1] !== qsel)
            value_error($sformatf("frame %0d went to quad index %b, expected %b",
                                  exp_frames, model_i.log_quad[exp_frames - 1], qsel));
    endtask

    task automatic check_frame_count();
        if (model_i.frame_cnt != exp_frames)
            value_error($sformatf("model saw %0d frames, expected %0d",
                                  model_i.frame_cnt, exp_frames));
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic idle_after_reset();
        logic [31:0] st;
        check_pins({sclk, ioexp_csn}, 3'b011, "after reset");
        read_reg(port_addr(4'd1), st);
        check_status(st, 32'd0, "Q1 after reset");
        read_reg(port_addr(4'd2), st);
        check_status(st, 32'd0, "Q2 after reset");
    endtask

    task automatic q1_write_read(input logic [7:0] d);
        logic [31:0] st;
        send_frame(4'd1, make_frame(1'b0, 7'h03, d));
        read_reg(port_addr(4'd1), st);
        check_status(st, done_status(16'h0000), "Q1 write");
        expect_logged(1'b0, make_frame(1'b0, 7'h03, d));
        send_frame(4'd1, make_frame(1'b1, 7'h03, 8'h00));
        read_reg(port_addr(4'd1), st);
        check_status(st, done_status({8'h00, d}), "Q1 read back");
        expect_logged(1'b0, make_frame(1'b1, 7'h03, 8'h00));
        check_frame_count();
    endtask

    task automatic q2_isolation(input logic [7:0] d);
        logic [31:0] st;
        send_frame(4'd2, make_frame(1'b0, 7'h05, d));
        expect_logged(1'b1, make_frame(1'b0, 7'h05, d));
        send_frame(4'd2, make_frame(1'b1, 7'h05, 8'h00));
        read_reg(port_addr(4'd2), st);
        check_status(st, done_status({8'h00, d}), "Q2 read back");
        expect_logged(1'b1, make_frame(1'b1, 7'h05, 8'h00));
        send_frame(4'd1, make_frame(1'b1, 7'h05, 8'h00));   // Q1 register 5 never written
        read_reg(port_addr(4'd1), st);
        check_status(st, done_status(16'h0000), "Q1 untouched by Q2 write");
        expect_logged(1'b0, make_frame(1'b1, 7'h05, 8'h00));
        check_frame_count();
    endtask

    task automatic back_to_back(input logic [7:0] a, input logic [7:0] b);
        logic [31:0] st;
        write_reg(port_addr(4'd1), make_frame(1'b0, 7'h06, a));
        write_reg(port_addr(4'd2), make_frame(1'b0, 7'h06, b));   // Next cycle
        end_write();
        wait_idle(4'd1);
        wait_idle(4'd2);
        read_reg(port_addr(4'd1), st);
        check_status(st, done_status(16'h0000), "Q1 contended");
        read_reg(port_addr(4'd2), st);
        check_status(st, done_status(16'h0000), "Q2 contended");
        expect_logged(1'b0, make_frame(1'b0, 7'h06, a));   // Q1 first
        expect_logged(1'b1, make_frame(1'b0, 7'h06, b));
        check_frame_count();
    endtask

    task automatic busy_write_dropped(input logic [7:0] d);
        logic [31:0] st;
        write_reg(port_addr(4'd1), make_frame(1'b1, 7'h03, 8'h00));
        end_write();
        write_reg(port_addr(4'd1), make_frame(1'b0, 7'h03, ~d));  // Port busy
        end_write();
        wait_idle(4'd1);
        read_reg(port_addr(4'd1), st);
        check_status(st, done_status({8'h00, d}), "Q1 after dropped write");
        expect_logged(1'b0, make_frame(1'b1, 7'h03, 8'h00));
        check_frame_count();
    endtask

    task automatic unmapped_read();
        logic [31:0] st;
        read_reg(16'h003C, st);                 // Channel 3
        check_status(st, 32'd0, "channel 3");
        read_reg(16'h000C, st);                 // Channel 0
        check_status(st, 32'd0, "channel 0");
        read_reg(16'h001B, st);                 // Wrong offset
        check_status(st, 32'd0, "offset 11");
        read_reg(16'h101C, st);                 // Wrong space
        check_status(st, 32'd0, "space 1");
    endtask

    // Shared wires, never two targets at once
    always @(negedge sysclk) begin
        if (arst_n && ioexp_csn == 2'b00) begin
            $display("Both chip selects were low in the same cycle");
            stop_run();
        end
    end

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYC);
        stop_run();
    end

    initial begin
        logic [7:0] d1;
        logic [7:0] d2;
        reg_raddr  = '0;
        reg_waddr  = '0;
        reg_wdata  = '0;
        reg_wen    = 1'b0;
        exp_frames = 0;
        void'($urandom(2472));
        d1 = 8'($urandom_range(255, 1));        // Nonzero, differs from reset value
        d2 = 8'($urandom_range(255, 1));
        @(posedge arst_n);
        @(negedge sysclk);
        idle_after_reset();
        q1_write_read(d1);
        q2_isolation(d2);
        back_to_back(8'($urandom_range(255, 0)), 8'($urandom_range(255, 0)));
        busy_write_dropped(d1);
        unmapped_read();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/dqla_pkg.sv
logic/spi_bus_if.sv
logic/ioexp_port.sv
logic/spi_bus_arbiter.sv
logic/spi_shifter.sv
logic/dqla_ioexp_top.sv
sim/tb_clock_gen.sv
sim/tb_ioexp_model.sv
sim/tb_dqla_ioexp.sv

// File: run_sim.sh
#!/bin/sh
# Build the expander link testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_dqla_ioexp \
    -f sim.f --Mdir obj_dir -o tb_dqla_ioexp
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_dqla_ioexp
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
